// File: Makefile
# Verilator build and run of the PMA checking stage testbench

TOP := tb_pma_top
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f flist.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
+incdir+include
verilog/pma_pkg.sv
verilog/pma_access_if.sv
verilog/pma_regs.sv
verilog/pma_checker.sv
verilog/pma_access_unit.sv
verilog/pma_top.sv
sim/tb_pma_top.sv

// File: include/pma_cfg.svh
//////////////////////////////////////////////////////////////////////
// PMA checking stage configuration
// Address width, region count and region index width shared by
// the register block, the access path and the checker
//////////////////////////////////////////////////////////////////////

`ifndef PMA_CFG_SVH
`define PMA_CFG_SVH

// Physical address width in bits
`define PMA_PLEN 32

// Number of PMA regions
`define PMA_CNT 4

// Width of a region index, log2 of the region count
`define PMA_IDX_W 2

`endif

// File: sim/tb_pma_top.sv
//////////////////////////////////////////////////////////////////////
// PMA checking stage testbench
// Register readback, region matching, priority, sanitizing, routes
// and handshake timing against a reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pma_cfg.svh"

module tb_pma_top;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_RAND   = 40;
  // Upper bound on register and access transactions over all tests
  localparam int NUM_TXN    = 2 * NUM_RAND + 120;
  localparam int ACK_LIMIT  = 16;

  logic                  clk_i = 1'b0;
  logic                  arst_n_i;
  logic                  cfg_req_i;
  logic                  cfg_we_i;
  logic                  cfg_sel_i;
  logic [`PMA_IDX_W-1:0] cfg_idx_i;
  logic [31:0]           cfg_wdata_i;
  logic                  cfg_ack_o;
  logic [31:0]           cfg_rdata_o;
  logic                  acc_req_i;
  logic                  acc_instr_i;
  logic                  acc_we_i;
  logic [`PMA_PLEN-1:0]  acc_adr_i;
  pma_pkg::acc_size_e    acc_size_i;
  logic                  acc_misaligned_i;
  logic                  acc_ack_o;
  pma_pkg::pma_attr_t    acc_attr_o;
  logic                  acc_exception_o;
  logic                  acc_misaligned_o;
  logic                  acc_is_cache_o;
  logic                  acc_is_ext_o;
  logic                  acc_is_tcm_o;

  // Attr, exception, misaligned, cache, ext, tcm
  logic [18:0]           result_bus;

  // Configuration mirror
  logic [13:0]           m_attr [`PMA_CNT];
  logic [`PMA_PLEN-3:0]  m_adr  [`PMA_CNT];

  logic [31:0]           lcg_state = 32'h23369044;
  int                    val_err   = 0;
  int                    proto_err = 0;

  assign result_bus = {acc_attr_o, acc_exception_o, acc_misaligned_o,
                       acc_is_cache_o, acc_is_ext_o, acc_is_tcm_o};

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  pma_top u_pma_top (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cfg_req_i        (cfg_req_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_sel_i        (cfg_sel_i),
    .cfg_idx_i        (cfg_idx_i),
    .cfg_wdata_i      (cfg_wdata_i),
    .cfg_ack_o        (cfg_ack_o),
    .cfg_rdata_o      (cfg_rdata_o),
    .acc_req_i        (acc_req_i),
    .acc_instr_i      (acc_instr_i),
    .acc_we_i         (acc_we_i),
    .acc_adr_i        (acc_adr_i),
    .acc_size_i       (acc_size_i),
    .acc_misaligned_i (acc_misaligned_i),
    .acc_ack_o        (acc_ack_o),
    .acc_attr_o       (acc_attr_o),
    .acc_exception_o  (acc_exception_o),
    .acc_misaligned_o (acc_misaligned_o),
    .acc_is_cache_o   (acc_is_cache_o),
    .acc_is_ext_o     (acc_is_ext_o),
    .acc_is_tcm_o     (acc_is_tcm_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Protocol assertions
  //////////////////////////////////////////////////////////////////////

  // Ack two edges after a fresh request
  ack_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(acc_req_i) |-> !acc_ack_o ##1 !acc_ack_o ##1 acc_ack_o)
  else begin
    proto_err++;
    $display("Access ack did not rise two cycles after the request at %0t", $time);
  end

  // Verdict frozen while ack is held
  result_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    acc_ack_o && $past(acc_ack_o) |-> $stable(result_bus))
  else begin
    proto_err++;
    $display("Access results changed while the ack was high at %0t", $time);
  end

  // Both acks and every result flag low out of reset
  reset_quiet: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !cfg_ack_o && !acc_ack_o && result_bus == '0)
  else begin
    proto_err++;
    $display("Outputs were not low after reset at %0t", $time);
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Attribute word in register layout, AMO fixed to SWAP
  function automatic logic [13:0] make_attr(input logic [1:0] mem, input logic [2:0] rwx,
                                            input logic cache, input logic mis_ok,
                                            input logic [1:0] mode);
    return {mem, rwx, cache, cache, 2'b00, mis_ok, 2'b01, mode};
  endfunction

  // Reference model on byte addresses
  function automatic logic [18:0] predict(input logic instr, input logic we,
                                          input logic [31:0] adr, input logic [2:0] size,
                                          input logic mis);
    longint unsigned    first;
    longint unsigned    last;
    longint unsigned    lo;
    longint unsigned    hi;
    longint unsigned    len;
    pma_pkg::pma_attr_t raw;
    pma_pkg::pma_attr_t san;
    logic               hit;
    logic               exc;
    logic               mis_o;
    logic               ok;
    int                 ones;
    hit   = 1'b0;
    san   = '0;
    first = adr;
    last  = first + (64'd1 << size) - 1;
    for (int r = 0; r < `PMA_CNT; r++) begin
      raw = pma_pkg::pma_attr_t'(m_attr[r]);
      if (!hit && raw.mode != pma_pkg::OFF) begin
        // Region bounds, upper one exclusive
        if (raw.mode == pma_pkg::TOR) begin
          lo = 0;
          if (r > 0) begin
            lo = 64'(m_adr[r-1]) << 2;
          end
          hi = 64'(m_adr[r]) << 2;
        end else begin
          ones = 0;
          while (raw.mode == pma_pkg::NAPOT && ones < 30 && m_adr[r][ones]) begin
            ones++;
          end
          len = (raw.mode == pma_pkg::NA4) ? 64'd4 : (64'd8 << ones);
          lo  = (64'(m_adr[r]) << 2) & ~(len - 1);
          hi  = lo + len;
        end
        if (first >= lo && last < hi) begin
          hit = 1'b1;
          san = raw;
          // EMPTY is IO without permissions
          if (raw.mem_type == pma_pkg::EMPTY) begin
            san.mem_type   = pma_pkg::IO;
            san.readable   = 1'b0;
            san.writable   = 1'b0;
            san.executable = 1'b0;
          end
          if (raw.mem_type != pma_pkg::MAIN) san.cacheable = 1'b0;
          if (!san.cacheable) san.coherent = 1'b0;
          if (raw.mem_type != pma_pkg::IO) begin
            san.rd_idem = 1'b1;
            san.wr_idem = 1'b1;
          end
        end
      end
    end
    exc   = !hit || (instr && !san.executable) || (we && !san.writable) ||
            (!we && !san.readable);
    mis_o = mis && !san.misalign_ok;
    ok    = !exc && !mis_o;
    return {san, exc, mis_o, ok && san.cacheable,
            ok && !san.cacheable && san.mem_type != pma_pkg::TCM,
            ok && san.mem_type == pma_pkg::TCM};
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      val_err++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Four-phase register transfer, mirror follows writes
  task automatic reg_xfer(input logic we, input logic sel, input logic [`PMA_IDX_W-1:0] idx,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    @(posedge clk_i);
    cfg_req_i   <= 1'b1;
    cfg_we_i    <= we;
    cfg_sel_i   <= sel;
    cfg_idx_i   <= idx;
    cfg_wdata_i <= wdata;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!cfg_ack_o && waited < ACK_LIMIT);
    if (!cfg_ack_o) begin
      proto_err++;
      $display("Register port never acknowledged a request");
    end
    rdata = cfg_rdata_o;
    if (we && sel) m_adr[idx] = wdata[`PMA_PLEN-3:0];
    if (we && !sel) m_attr[idx] = wdata[13:0];
    cfg_req_i <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (cfg_ack_o && waited < ACK_LIMIT);
    if (cfg_ack_o) begin
      proto_err++;
      $display("Register ack stayed high after the request dropped");
    end
  endtask

  task automatic program_region(input int idx, input logic [13:0] attr,
                                input logic [`PMA_PLEN-3:0] adr);
    logic [31:0] dummy;
    reg_xfer(1'b1, 1'b0, `PMA_IDX_W'(idx), {18'b0, attr}, dummy);
    reg_xfer(1'b1, 1'b1, `PMA_IDX_W'(idx), {2'b00, adr}, dummy);
  endtask

  // Four-phase access, held for extra cycles, checked against the model
  task automatic run_access(input string name, input logic instr, input logic we,
                            input logic [31:0] adr, input logic [2:0] size, input logic mis,
                            input int hold, output logic [18:0] got);
    int waited;
    @(posedge clk_i);
    acc_req_i        <= 1'b1;
    acc_instr_i      <= instr;
    acc_we_i         <= we;
    acc_adr_i        <= adr;
    acc_size_i       <= pma_pkg::acc_size_e'(size);
    acc_misaligned_i <= mis;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!acc_ack_o && waited < ACK_LIMIT);
    if (!acc_ack_o) begin
      proto_err++;
      $display("Access port never acknowledged %s", name);
    end
    got = result_bus;
    expect_eq(name, {13'b0, predict(instr, we, adr, size, mis)}, {13'b0, got});
    for (int h = 0; h < hold; h++) begin
      @(posedge clk_i);
      if (!acc_ack_o) begin
        proto_err++;
        $display("Access ack dropped while the request was held");
      end
    end
    acc_req_i <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (acc_ack_o && waited < ACK_LIMIT);
    if (acc_ack_o) begin
      proto_err++;
      $display("Access ack stayed high after the request dropped");
    end
  endtask

  task automatic random_accesses(input string name, input int n, input logic [31:0] mask);
    logic [31:0] rnd;
    logic [18:0] got;
    for (int k = 0; k < n; k++) begin
      rnd = next_rand();
      // Fetches only on reads, sizes BYTE to QWORD
      run_access(name, !rnd[20] && rnd[21], rnd[20], next_rand() & mask,
                 rnd[26:24] % 3'd5, rnd[22], 0, got);
    end
  endtask

  task automatic apply_reset();
    arst_n_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    for (int r = 0; r < `PMA_CNT; r++) begin
      m_attr[r] = '0;
      m_adr[r]  = '0;
    end
    @(posedge clk_i);
    expect_eq("reset flags", 32'h0, {cfg_ack_o, acc_ack_o, result_bus});
    expect_eq("reset rdata", 32'h0, cfg_rdata_o);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watchdog and test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    #(CLK_PERIOD * (NUM_TXN * 20 + 1000));
    $display("Watchdog expired before the tests completed");
    $display("test failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] rd;
    logic [18:0] got;
    cfg_req_i        <= 1'b0;
    cfg_we_i         <= 1'b0;
    cfg_sel_i        <= 1'b0;
    cfg_idx_i        <= '0;
    cfg_wdata_i      <= '0;
    acc_req_i        <= 1'b0;
    acc_instr_i      <= 1'b0;
    acc_we_i         <= 1'b0;
    acc_adr_i        <= '0;
    acc_size_i       <= pma_pkg::BYTE;
    acc_misaligned_i <= 1'b0;
    apply_reset();

    // Readback of random words, upper bits dropped
    for (int r = 0; r < `PMA_CNT; r++) begin
      reg_xfer(1'b1, 1'b0, `PMA_IDX_W'(r), next_rand(), rd);
      reg_xfer(1'b1, 1'b1, `PMA_IDX_W'(r), next_rand(), rd);
    end
    for (int r = 0; r < `PMA_CNT; r++) begin
      reg_xfer(1'b0, 1'b0, `PMA_IDX_W'(r), 32'h0, rd);
      expect_eq("readback attr", {18'b0, m_attr[r]}, rd);
      reg_xfer(1'b0, 1'b1, `PMA_IDX_W'(r), 32'h0, rd);
      expect_eq("readback addr", {2'b00, m_adr[r]}, rd);
    end

    // TOR main 0x0000..0x0fff, NAPOT IO 0x2000..0x2fff
    program_region(0, make_attr(pma_pkg::MAIN, 3'b111, 1'b1, 1'b1, pma_pkg::TOR), 30'h400);
    program_region(1, make_attr(pma_pkg::IO, 3'b110, 1'b0, 1'b0, pma_pkg::NAPOT), 30'h9FF);
    program_region(2, 14'h0, 30'h0);
    program_region(3, 14'h0, 30'h0);
    run_access("tor straddle", 1'b0, 1'b0, 32'h0FFE, 3'd2, 1'b0, 0, got);
    expect_eq("tor straddle fault", 32'h1, got[4]);
    run_access("napot straddle", 1'b0, 1'b1, 32'h2FFC, 3'd3, 1'b0, 0, got);
    expect_eq("napot straddle fault", 32'h1, got[4]);
    random_accesses("tor napot random", NUM_RAND, 32'h3FFF);

    // Overlap at 0x3000 and permission faults
    program_region(0, make_attr(pma_pkg::IO, 3'b100, 1'b0, 1'b0, pma_pkg::NA4), 30'hC00);
    program_region(1, make_attr(pma_pkg::MAIN, 3'b111, 1'b1, 1'b1, pma_pkg::NAPOT), 30'hDFF);
    program_region(2, make_attr(pma_pkg::MAIN, 3'b110, 1'b1, 1'b1, pma_pkg::NA4), 30'h1000);
    program_region(3, make_attr(pma_pkg::IO, 3'b010, 1'b0, 1'b0, pma_pkg::NAPOT), 30'h15FF);
    run_access("priority write", 1'b0, 1'b1, 32'h3000, 3'd2, 1'b0, 0, got);
    expect_eq("priority write fault", 32'h1, got[4]);
    expect_eq("priority mode", 32'(pma_pkg::NA4), got[6:5]);
    run_access("priority read", 1'b0, 1'b0, 32'h3000, 3'd2, 1'b0, 0, got);
    run_access("lower region miss", 1'b0, 1'b0, 32'h3004, 3'd2, 1'b0, 0, got);
    run_access("fetch no exec", 1'b1, 1'b0, 32'h4000, 3'd2, 1'b0, 0, got);
    expect_eq("fetch no exec fault", 32'h1, got[4]);
    run_access("read no read", 1'b0, 1'b0, 32'h5000, 3'd2, 1'b0, 0, got);
    expect_eq("read no read fault", 32'h1, got[4]);
    run_access("write only", 1'b0, 1'b1, 32'h5000, 3'd2, 1'b0, 0, got);
    random_accesses("priority random", NUM_RAND / 2, 32'h7FFF);

    // EMPTY with every permission, IO with cacheable set
    program_region(0, make_attr(pma_pkg::EMPTY, 3'b111, 1'b1, 1'b1, pma_pkg::NAPOT), 30'h1FF);
    program_region(1, make_attr(pma_pkg::IO, 3'b110, 1'b1, 1'b0, pma_pkg::NAPOT), 30'h5FF);
    program_region(2, 14'h0, 30'h0);
    program_region(3, 14'h0, 30'h0);
    for (int k = 0; k < 3; k++) begin
      run_access("empty", k == 2, k == 1, 32'h0100, 3'd2, 1'b0, 0, got);
      expect_eq("empty fault", 32'h1, got[4]);
      expect_eq("empty as io", 32'(pma_pkg::IO), got[18:17]);
    end
    run_access("io cacheable", 1'b0, 1'b0, 32'h1000, 3'd2, 1'b0, 0, got);
    expect_eq("io cacheable route", 32'h2, got[2:0]);
    random_accesses("sanitize random", NUM_RAND / 2, 32'h1FFF);

    // TCM without misalign, main with misalign
    program_region(0, make_attr(pma_pkg::TCM, 3'b111, 1'b0, 1'b0, pma_pkg::NAPOT), 30'h21FF);
    program_region(1, make_attr(pma_pkg::MAIN, 3'b111, 1'b1, 1'b1, pma_pkg::NAPOT), 30'h25FF);
    run_access("tcm", 1'b0, 1'b0, 32'h8010, 3'd2, 1'b0, 0, got);
    expect_eq("tcm route", 32'h1, got[2:0]);
    run_access("tcm misaligned", 1'b0, 1'b0, 32'h8012, 3'd2, 1'b1, 0, got);
    expect_eq("tcm misaligned flag", 32'h1, got[3]);
    expect_eq("tcm misaligned route", 32'h0, got[2:0]);
    run_access("main misaligned", 1'b0, 1'b0, 32'h9012, 3'd2, 1'b1, 0, got);
    expect_eq("main misaligned flag", 32'h0, got[3]);
    expect_eq("main misaligned route", 32'h4, got[2:0]);

    // Held request, then back to back, then reset clears the regions
    run_access("held", 1'b0, 1'b1, 32'h9000, 3'd3, 1'b0, 6, got);
    run_access("back to back", 1'b1, 1'b0, 32'h8000, 3'd4, 1'b0, 0, got);
    apply_reset();
    run_access("after reset", 1'b0, 1'b0, 32'h9000, 3'd2, 1'b0, 0, got);
    expect_eq("after reset fault", 32'h1, got[4]);

    $display("Errors: %0d value, %0d protocol", val_err, proto_err);
    if (val_err == 0 && proto_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/pma_access_if.sv
//////////////////////////////////////////////////////////////////////
// PMA access interface
// One captured access from the front end to the checker and the
// checker verdict coming back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pma_cfg.svh"

interface pma_access_if;

  // Captured access, valid while the front end is busy
  logic                 valid;
  logic                 instr;
  logic [`PMA_PLEN-1:0] adr;
  pma_pkg::acc_size_e   size;
  logic                 we;
  logic                 misaligned;

  // Checker verdict
  pma_pkg::pma_attr_t   attr;
  logic                 exception;
  logic                 misaligned_out;
  logic                 is_cache;
  logic                 is_ext;
  logic                 is_tcm;

  // Front end side
  modport issue (
    output valid, instr, adr, size, we, misaligned,
    input  attr, exception, misaligned_out, is_cache, is_ext, is_tcm
  );

  // Checker side
  modport check (
    input  valid, instr, adr, size, we, misaligned,
    output attr, exception, misaligned_out, is_cache, is_ext, is_tcm
  );

endinterface

`default_nettype wire

// File: verilog/pma_access_unit.sv
//////////////////////////////////////////////////////////////////////
// PMA access front end
// Captures a four-phase access, lets the checker run for one cycle,
// then registers the verdict and raises the ack
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pma_cfg.svh"

module pma_access_unit (
  input  wire                   clk_i,
  input  wire                   arst_n_i,
  // Access request
  input  wire                   acc_req_i,
  input  wire                   acc_instr_i,
  input  wire                   acc_we_i,
  input  wire [`PMA_PLEN-1:0]   acc_adr_i,
  input  pma_pkg::acc_size_e    acc_size_i,
  input  wire                   acc_misaligned_i,
  // Response
  output logic                  acc_ack_o,
  output pma_pkg::pma_attr_t    acc_attr_o,
  output logic                  acc_exception_o,
  output logic                  acc_misaligned_o,
  output logic                  acc_is_cache_o,
  output logic                  acc_is_ext_o,
  output logic                  acc_is_tcm_o,
  // To the checker
  pma_access_if.issue           acc
);

  logic busy_q;
  logic ack_q;
  logic capture;
  logic respond;
  logic ack_drop;

  // Edge 1 capture, edge 2 respond, then wait for request low
  assign capture  = acc_req_i & ~ack_q & ~busy_q;
  assign respond  = busy_q & ~ack_q;
  assign ack_drop = ack_q & ~acc_req_i;

  // Access fields
  always_ff @(posedge clk_i) begin
    if (capture) begin
      acc.instr      <= acc_instr_i;
      acc.we         <= acc_we_i;
      acc.adr        <= acc_adr_i;
      acc.size       <= acc_size_i;
      acc.misaligned <= acc_misaligned_i;
    end
  end

  // Checker only sees a live access while busy
  assign acc.valid = busy_q;

  //////////////////////////////////////////////////////////////////////
  // Sequencing and result registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q           <= 1'b0;
      ack_q            <= 1'b0;
      acc_attr_o       <= '0;
      acc_exception_o  <= 1'b0;
      acc_misaligned_o <= 1'b0;
      acc_is_cache_o   <= 1'b0;
      acc_is_ext_o     <= 1'b0;
      acc_is_tcm_o     <= 1'b0;
    end else if (capture) begin
      busy_q <= 1'b1;
    end else if (respond) begin
      // Verdict frozen here until the next response
      ack_q            <= 1'b1;
      acc_attr_o       <= acc.attr;
      acc_exception_o  <= acc.exception;
      acc_misaligned_o <= acc.misaligned_out;
      acc_is_cache_o   <= acc.is_cache;
      acc_is_ext_o     <= acc.is_ext;
      acc_is_tcm_o     <= acc.is_tcm;
    end else if (ack_drop) begin
      ack_q  <= 1'b0;
      busy_q <= 1'b0;
    end
  end

  assign acc_ack_o = ack_q;

endmodule

`default_nettype wire

// File: verilog/pma_checker.sv
//////////////////////////////////////////////////////////////////////
// PMA checker
// Sanitizes region attributes, builds region bounds, picks the
// lowest matching region and derives exception, misalign and route
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pma_cfg.svh"

module pma_checker (
  input  pma_pkg::pma_attr_t [`PMA_CNT-1:0]  pma_attr_i,
  input  wire [`PMA_CNT-1:0][`PMA_PLEN-3:0]  pma_adr_i,
  pma_access_if.check                        acc
);

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Byte count of a transfer
  function automatic logic [4:0] size2bytes(input pma_pkg::acc_size_e size);
    case (size)
      pma_pkg::BYTE:  return 5'd1;
      pma_pkg::HWORD: return 5'd2;
      pma_pkg::WORD:  return 5'd4;
      pma_pkg::DWORD: return 5'd8;
      pma_pkg::QWORD: return 5'd16;
      default:        return 5'd1;
    endcase
  endfunction

  // NAPOT span in words, 2^(trailing ones + 1)
  function automatic logic [`PMA_PLEN-1:0] napot_span(input logic [`PMA_PLEN-3:0] pmaddr);
    logic [`PMA_PLEN-1:0] span;
    logic                 done;
    span = `PMA_PLEN'(2);
    done = 1'b0;
    for (int b = 0; b < `PMA_PLEN - 2; b++) begin
      if (!done) begin
        if (pmaddr[b]) begin
          span = span << 1;
        end else begin
          done = 1'b1;
        end
      end
    end
    return span;
  endfunction

  pma_pkg::pma_attr_t [`PMA_CNT-1:0] attr_s;
  logic [`PMA_PLEN-1:0]              pma_lb [`PMA_CNT];
  logic [`PMA_PLEN-1:0]              pma_ub [`PMA_CNT];
  logic [`PMA_CNT-1:0]               match_all;

  // Access bounds as word addresses, one spare bit for wrap
  logic [`PMA_PLEN:0]                acc_ub_b;
  logic [`PMA_PLEN-1:0]              acc_lb_w;
  logic [`PMA_PLEN-1:0]              acc_ub_w;

  logic [`PMA_IDX_W-1:0]             hit_idx;
  logic                              hit;
  pma_pkg::pma_attr_t                hit_attr;
  logic                              fault;

  assign acc_ub_b = {1'b0, acc.adr} + {{(`PMA_PLEN-4){1'b0}}, size2bytes(acc.size)} - 1'b1;
  assign acc_lb_w = {2'b00, acc.adr[`PMA_PLEN-1:2]};
  assign acc_ub_w = {1'b0, acc_ub_b[`PMA_PLEN:2]};

  //////////////////////////////////////////////////////////////////////
  // Per region sanitize, bounds and match
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `PMA_CNT; i++) begin : gen_region
    logic [`PMA_PLEN-1:0] tor_base;
    logic [`PMA_PLEN-1:0] own_adr;
    logic [`PMA_PLEN-1:0] span;

    // TOR starts at the previous region's address, or at zero
    if (i == 0) begin : gen_first
      assign tor_base = '0;
    end else begin : gen_next
      assign tor_base = {2'b00, pma_adr_i[i-1]};
    end

    assign own_adr = {2'b00, pma_adr_i[i]};

    always_comb begin
      attr_s[i] = pma_attr_i[i];
      // EMPTY reads as IO with no permissions
      if (pma_attr_i[i].mem_type == pma_pkg::EMPTY) begin
        attr_s[i].mem_type   = pma_pkg::IO;
        attr_s[i].readable   = 1'b0;
        attr_s[i].writable   = 1'b0;
        attr_s[i].executable = 1'b0;
      end
      // Only main memory may be cached
      attr_s[i].cacheable = pma_attr_i[i].cacheable &
                            (pma_attr_i[i].mem_type == pma_pkg::MAIN);
      attr_s[i].coherent  = pma_attr_i[i].coherent & attr_s[i].cacheable;
      // Side effects only exist on IO
      if (pma_attr_i[i].mem_type != pma_pkg::IO) begin
        attr_s[i].rd_idem = 1'b1;
        attr_s[i].wr_idem = 1'b1;
      end
    end

    // NA4 is a one word span
    assign span = (pma_attr_i[i].mode == pma_pkg::NA4) ? `PMA_PLEN'(1)
                                                       : napot_span(pma_adr_i[i]);

    always_comb begin
      if (pma_attr_i[i].mode == pma_pkg::TOR) begin
        pma_lb[i] = tor_base;
        pma_ub[i] = own_adr;
      end else begin
        pma_lb[i] = own_adr & ~(span - 1'b1);
        pma_ub[i] = (own_adr & ~(span - 1'b1)) + span;
      end
    end

    // All bytes inside, upper bound exclusive
    assign match_all[i] = (pma_attr_i[i].mode != pma_pkg::OFF) &&
                          (acc_lb_w >= pma_lb[i]) && (acc_ub_w < pma_ub[i]);
  end

  //////////////////////////////////////////////////////////////////////
  // Priority select and verdict
  //////////////////////////////////////////////////////////////////////

  // Lowest index wins
  always_comb begin
    hit_idx = '0;
    for (int i = `PMA_CNT - 1; i >= 0; i--) begin
      if (match_all[i]) begin
        hit_idx = `PMA_IDX_W'(i);
      end
    end
  end

  assign hit      = |match_all;
  assign hit_attr = hit ? attr_s[hit_idx] : '0;

  assign acc.attr      = hit_attr;
  assign acc.exception = acc.valid & (~hit |
                                      (acc.instr & ~hit_attr.executable) |
                                      (acc.we & ~hit_attr.writable) |
                                      (~acc.we & ~hit_attr.readable));

  assign acc.misaligned_out = acc.misaligned & ~hit_attr.misalign_ok;

  // Either fault blocks every route
  assign fault = acc.exception | acc.misaligned_out;

  assign acc.is_cache = acc.valid & ~fault & hit_attr.cacheable;
  assign acc.is_tcm   = acc.valid & ~fault & (hit_attr.mem_type == pma_pkg::TCM);
  assign acc.is_ext   = acc.valid & ~fault & ~hit_attr.cacheable &
                        (hit_attr.mem_type != pma_pkg::TCM);

endmodule

`default_nettype wire

// File: verilog/pma_pkg.sv
//////////////////////////////////////////////////////////////////////
// PMA types
// Memory, AMO, match mode and transfer size encodings plus the
// packed 14-bit region attribute word
//////////////////////////////////////////////////////////////////////

`default_nettype none

package pma_pkg;

  // Memory type, EMPTY is treated as IO without permissions
  typedef enum logic [1:0] {
    EMPTY = 2'd0,
    MAIN  = 2'd1,
    IO    = 2'd2,
    TCM   = 2'd3
  } mem_type_e;

  // AMO class, stored and reported only
  typedef enum logic [1:0] {
    NONE    = 2'd0,
    SWAP    = 2'd1,
    LOGICAL = 2'd2,
    ARITH   = 2'd3
  } amo_type_e;

  // Address matching mode, pmpcfg style
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pma_mode_e;

  // Transfer size, log2 of the byte count
  typedef enum logic [2:0] {
    BYTE  = 3'd0,
    HWORD = 3'd1,
    WORD  = 3'd2,
    DWORD = 3'd3,
    QWORD = 3'd4
  } acc_size_e;

  // Attribute word, bit 13 down to bit 0
  typedef struct packed {
    mem_type_e mem_type;    // [13:12]
    logic      readable;    // [11]
    logic      writable;    // [10]
    logic      executable;  // [9]
    logic      cacheable;   // [8]
    logic      coherent;    // [7]
    logic      rd_idem;     // [6]
    logic      wr_idem;     // [5]
    logic      misalign_ok; // [4]
    amo_type_e amo_type;    // [3:2]
    pma_mode_e mode;        // [1:0]
  } pma_attr_t;

endpackage

`default_nettype wire

// File: verilog/pma_regs.sv
//////////////////////////////////////////////////////////////////////
// PMA configuration registers
// Attribute word and pmaddr style word address per region, written
// and read over a four-phase req/ack register port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pma_cfg.svh"

module pma_regs (
  input  wire                                       clk_i,
  input  wire                                       arst_n_i,
  // Register port
  input  wire                                       cfg_req_i,
  input  wire                                       cfg_we_i,
  input  wire                                       cfg_sel_i,
  input  wire  [`PMA_IDX_W-1:0]                     cfg_idx_i,
  input  wire  [31:0]                               cfg_wdata_i,
  output logic                                      cfg_ack_o,
  output logic [31:0]                               cfg_rdata_o,
  // Configuration to the checker
  output pma_pkg::pma_attr_t [`PMA_CNT-1:0]         pma_attr_o,
  output logic [`PMA_CNT-1:0][`PMA_PLEN-3:0]        pma_adr_o
);

  pma_pkg::pma_attr_t [`PMA_CNT-1:0]  attr_q;
  logic [`PMA_CNT-1:0][`PMA_PLEN-3:0] adr_q;
  logic                               ack_q;
  logic [31:0]                        rd_word;
  logic                               take;

  // New request seen while the ack is still low
  assign take = cfg_req_i & ~ack_q;

  // Readback word, zero-extended
  always_comb begin
    rd_word = '0;
    if (cfg_sel_i) begin
      rd_word[`PMA_PLEN-3:0] = adr_q[cfg_idx_i];
    end else begin
      rd_word[13:0] = attr_q[cfg_idx_i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register array and handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // Every region comes up OFF
      attr_q      <= '0;
      adr_q       <= '0;
      ack_q       <= 1'b0;
      cfg_rdata_o <= '0;
    end else if (take) begin
      if (cfg_we_i && cfg_sel_i) begin
        adr_q[cfg_idx_i] <= cfg_wdata_i[`PMA_PLEN-3:0];
      end else if (cfg_we_i) begin
        attr_q[cfg_idx_i] <= pma_pkg::pma_attr_t'(cfg_wdata_i[13:0]);
      end else begin
        cfg_rdata_o <= rd_word;
      end
      ack_q <= 1'b1;
    end else if (!cfg_req_i) begin
      // Requester released, close the four-phase cycle
      ack_q <= 1'b0;
    end
  end

  assign cfg_ack_o  = ack_q;
  assign pma_attr_o = attr_q;
  assign pma_adr_o  = adr_q;

endmodule

`default_nettype wire

// File: verilog/pma_top.sv
//////////////////////////////////////////////////////////////////////
// PMA checking stage top level
// Register block, access front end and checker on plain ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pma_cfg.svh"

module pma_top (
  input  wire                   clk_i,
  input  wire                   arst_n_i,
  // Register port
  input  wire                   cfg_req_i,
  input  wire                   cfg_we_i,
  input  wire                   cfg_sel_i,
  input  wire [`PMA_IDX_W-1:0]  cfg_idx_i,
  input  wire [31:0]            cfg_wdata_i,
  output logic                  cfg_ack_o,
  output logic [31:0]           cfg_rdata_o,
  // Access port
  input  wire                   acc_req_i,
  input  wire                   acc_instr_i,
  input  wire                   acc_we_i,
  input  wire [`PMA_PLEN-1:0]   acc_adr_i,
  input  pma_pkg::acc_size_e    acc_size_i,
  input  wire                   acc_misaligned_i,
  output logic                  acc_ack_o,
  output pma_pkg::pma_attr_t    acc_attr_o,
  output logic                  acc_exception_o,
  output logic                  acc_misaligned_o,
  output logic                  acc_is_cache_o,
  output logic                  acc_is_ext_o,
  output logic                  acc_is_tcm_o
);

  // Live configuration
  pma_pkg::pma_attr_t [`PMA_CNT-1:0]  pma_attr;
  logic [`PMA_CNT-1:0][`PMA_PLEN-3:0] pma_adr;

  // Captured access and verdict
  pma_access_if u_acc_if ();

  pma_regs u_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_sel_i   (cfg_sel_i),
    .cfg_idx_i   (cfg_idx_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rdata_o (cfg_rdata_o),
    .pma_attr_o  (pma_attr),
    .pma_adr_o   (pma_adr)
  );

  pma_access_unit u_access (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .acc_req_i        (acc_req_i),
    .acc_instr_i      (acc_instr_i),
    .acc_we_i         (acc_we_i),
    .acc_adr_i        (acc_adr_i),
    .acc_size_i       (acc_size_i),
    .acc_misaligned_i (acc_misaligned_i),
    .acc_ack_o        (acc_ack_o),
    .acc_attr_o       (acc_attr_o),
    .acc_exception_o  (acc_exception_o),
    .acc_misaligned_o (acc_misaligned_o),
    .acc_is_cache_o   (acc_is_cache_o),
    .acc_is_ext_o     (acc_is_ext_o),
    .acc_is_tcm_o     (acc_is_tcm_o),
    .acc              (u_acc_if.issue)
  );

  pma_checker u_checker (
    .pma_attr_i (pma_attr),
    .pma_adr_i  (pma_adr),
    .acc        (u_acc_if.check)
  );

endmodule

`default_nettype wire
